/* source/peakHistPkg.sv */
`default_nettype none

package peakHistPkg;

    localparam int SAMPLE_W = 12;             // timestamp width
    localparam int BIN_W = 4;                 // bin index width
    localparam int NUM_BINS = 1 << BIN_W;     // bins per pixel
    localparam int COUNT_W = 8;               // per-bin counter width
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // fine window is centred on the coarse bin start
    localparam logic [SAMPLE_W-1:0] WIN_HALF = SAMPLE_W'(1 << (BIN_W - 1));
    localparam logic [SAMPLE_W-1:0] WIN_MAX_START = SAMPLE_W'((1 << SAMPLE_W) - (1 << BIN_W));

    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL = 'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 'h04;
    localparam logic [APB_ADDR_W-1:0] ADDR_RESULT_BASE = 'h10;

    typedef enum logic [2:0] {
        COARSE,
        DRAIN_C,
        FINE,
        DRAIN_F,
        DONE
    } passState_e;

    // one timestamp, read whole or split into coarse bin and residual
    typedef union packed {
        logic [SAMPLE_W-1:0] raw;
        struct packed {
            logic [BIN_W-1:0] bin;
            logic [SAMPLE_W-BIN_W-1:0] residual;
        } coarse;
    } sampleWord_u;

    // clamped start of the fine window around a coarse centre
    function automatic logic [SAMPLE_W-1:0] windowStart(input logic [SAMPLE_W-1:0] centre);
        logic [SAMPLE_W-1:0] start;
        if (centre < WIN_HALF) begin
            start = '0;                       // clip at zero
        end else begin
            start = centre - WIN_HALF;
        end
        if (start > WIN_MAX_START) begin
            start = WIN_MAX_START;            // keep window inside range
        end
        return start;
    endfunction

endpackage

`default_nettype wire

/* source/passSequencer.sv */
`default_nettype none

module passSequencer (
    input  wire logic                    clk,
    input  wire logic                    combin_res,
    input  wire logic                    passEnd,
    input  wire logic                    restart,
    output logic                         ready,
    output logic                         finePass,
    output logic                         clearBins,
    output logic                         latchCoarse,
    output logic                         latchFine,
    output peakHistPkg::passState_e      state
);
    import peakHistPkg::*;

    logic drainCnt;                           // second drain cycle flag

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= COARSE;
            drainCnt <= 1'b0;
        end else begin
            drainCnt <= (state == DRAIN_C || state == DRAIN_F) ? ~drainCnt : 1'b0;
            case (state)
                COARSE:  if (passEnd) state <= DRAIN_C;
                DRAIN_C: if (drainCnt) state <= FINE;
                FINE:    if (passEnd) state <= DRAIN_F;
                DRAIN_F: if (drainCnt) state <= DONE;
                DONE:    if (restart) state <= COARSE;
                default: state <= COARSE;
            endcase
        end
    end

    always_comb begin
        ready = (state == COARSE) || (state == FINE);
        finePass = (state == FINE);
        latchCoarse = (state == DRAIN_C) && drainCnt;   // last coarse count has settled
        latchFine = (state == DRAIN_F) && drainCnt;
        // histograms clear on the FINE entry edge and on a restart
        clearBins = latchCoarse || ((state == DONE) && restart);
    end

endmodule

`default_nettype wire

/* source/sampleCounter.sv */
`default_nettype none

module sampleCounter #(
    parameter int PIXELS = 4,
    parameter int SAMPLES = 8,
    parameter int ACQS = 2
) (
    input  wire logic                                   clk,
    input  wire logic                                   combin_res,
    input  wire logic                                   accept,
    input  wire logic                                   clearBins,
    output logic [((PIXELS > 1) ? $clog2(PIXELS) : 1)-1:0] pixel,
    output logic                                        passEnd
);
    localparam int PIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam int SMP_W = (SAMPLES > 1) ? $clog2(SAMPLES) : 1;
    localparam int ACQ_W = (ACQS > 1) ? $clog2(ACQS) : 1;

    logic [SMP_W-1:0] sampleIdx;              // sample within pixel
    logic [ACQ_W-1:0] acqIdx;                 // acquisition number
    logic sampleLast;
    logic pixelLast;
    logic acqLast;

    always_comb begin
        sampleLast = (sampleIdx == SMP_W'(SAMPLES - 1));
        pixelLast = (pixel == PIX_W'(PIXELS - 1));
        acqLast = (acqIdx == ACQ_W'(ACQS - 1));
        passEnd = accept && sampleLast && pixelLast && acqLast;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleIdx <= '0;
            pixel <= '0;
            acqIdx <= '0;
        end else if (clearBins) begin
            sampleIdx <= '0;
            pixel <= '0;
            acqIdx <= '0;
        end else if (accept) begin
            if (!sampleLast) begin
                sampleIdx <= sampleIdx + 1'b1;
            end else begin
                sampleIdx <= '0;
                if (!pixelLast) begin
                    pixel <= pixel + 1'b1;
                end else begin
                    pixel <= '0;
                    acqIdx <= acqLast ? '0 : acqIdx + 1'b1;   // wraps at pass end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/binMapper.sv */
`default_nettype none

module binMapper #(
    parameter int PIXELS = 4
) (
    input  wire peakHistPkg::sampleWord_u                    data,
    input  wire logic                                        finePass,
    input  wire logic [((PIXELS > 1) ? $clog2(PIXELS) : 1)-1:0] pixel,
    input  wire logic [PIXELS*peakHistPkg::BIN_W-1:0]       coarsePeak,
    output logic [peakHistPkg::BIN_W-1:0]                    binIdx,
    output logic                                             inWindow
);
    import peakHistPkg::*;

    sampleWord_u centre;                      // start of the coarse peak bin
    logic [SAMPLE_W-1:0] winStart;
    logic [SAMPLE_W-1:0] offset;

    always_comb begin
        centre.coarse.bin = coarsePeak[pixel*BIN_W +: BIN_W];
        centre.coarse.residual = '0;
        winStart = windowStart(centre.raw);
        offset = data.raw - winStart;

        if (finePass) begin
            // full resolution inside the window only
            inWindow = (data.raw >= winStart) && (offset <= SAMPLE_W'(NUM_BINS - 1));
            binIdx = offset[BIN_W-1:0];
        end else begin
            inWindow = 1'b1;
            binIdx = data.coarse.bin;         // top bits pick the coarse bin
        end
    end

endmodule

`default_nettype wire

/* source/histogramBins.sv */
`default_nettype none

module histogramBins #(
    parameter int PIXELS = 4
) (
    input  wire logic                                        clk,
    input  wire logic                                        combin_res,
    input  wire logic                                        accept,
    input  wire logic                                        inWindow,
    input  wire logic [((PIXELS > 1) ? $clog2(PIXELS) : 1)-1:0] pixel,
    input  wire logic [peakHistPkg::BIN_W-1:0]               binIdx,
    input  wire logic                                        clearBins,
    output logic [peakHistPkg::COUNT_W-1:0]                  newCount,
    output logic [peakHistPkg::BIN_W-1:0]                    binOut,
    output logic [((PIXELS > 1) ? $clog2(PIXELS) : 1)-1:0]   pixelOut,
    output logic                                             countValid
);
    import peakHistPkg::*;

    logic [COUNT_W-1:0] binCount [PIXELS][NUM_BINS];
    logic [PIXELS-1:0][NUM_BINS-1:0] binValid;      // bin holds a live count
    logic hit;

    assign hit = accept && inWindow;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            countValid <= 1'b0;
        end else begin
            countValid <= hit;
            if (clearBins) begin
                binValid <= '0;               // whole histogram in one cycle
            end else if (hit) begin
                binValid[pixel][binIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (binValid[pixel][binIdx]) begin
                binCount[pixel][binIdx] <= binCount[pixel][binIdx] + 1'b1;
                newCount <= binCount[pixel][binIdx] + 1'b1;
            end else begin
                binCount[pixel][binIdx] <= COUNT_W'(1);     // first hit
                newCount <= COUNT_W'(1);
            end
            binOut <= binIdx;
            pixelOut <= pixel;
        end
    end

endmodule

`default_nettype wire

/* source/peakTracker.sv */
`default_nettype none

module peakTracker #(
    parameter int PIXELS = 4
) (
    input  wire logic                                        clk,
    input  wire logic                                        combin_res,
    input  wire logic                                        countValid,
    input  wire logic [peakHistPkg::COUNT_W-1:0]             newCount,
    input  wire logic [peakHistPkg::BIN_W-1:0]               binOut,
    input  wire logic [((PIXELS > 1) ? $clog2(PIXELS) : 1)-1:0] pixelOut,
    input  wire logic                                        clearBins,
    input  wire logic                                        latchCoarse,
    input  wire logic                                        latchFine,
    output logic [PIXELS*peakHistPkg::BIN_W-1:0]             coarsePeak,
    output logic [PIXELS*peakHistPkg::SAMPLE_W-1:0]          result
);
    import peakHistPkg::*;

    logic [COUNT_W-1:0] maxCount [PIXELS];
    logic [BIN_W-1:0] maxBin [PIXELS];
    logic [SAMPLE_W-1:0] fineResult [PIXELS];

    always_comb begin
        sampleWord_u centre;
        for (int p = 0; p < PIXELS; p++) begin
            centre.coarse.bin = coarsePeak[p*BIN_W +: BIN_W];
            centre.coarse.residual = '0;
            fineResult[p] = windowStart(centre.raw) + SAMPLE_W'(maxBin[p]);
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXELS; p++) begin
                maxCount[p] <= '0;
                maxBin[p] <= '0;
            end
            coarsePeak <= '0;
            result <= '0;
        end else begin
            if (clearBins) begin
                for (int p = 0; p < PIXELS; p++) begin
                    maxCount[p] <= '0;
                    maxBin[p] <= '0;          // empty pixel falls back to bin 0
                end
            end else if (countValid && (newCount > maxCount[pixelOut])) begin
                maxCount[pixelOut] <= newCount;     // strict, so ties keep the first bin
                maxBin[pixelOut] <= binOut;
            end
            if (latchCoarse) begin
                for (int p = 0; p < PIXELS; p++) begin
                    coarsePeak[p*BIN_W +: BIN_W] <= maxBin[p];
                end
            end
            if (latchFine) begin
                for (int p = 0; p < PIXELS; p++) begin
                    result[p*SAMPLE_W +: SAMPLE_W] <= fineResult[p];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/apbResultPort.sv */
`default_nettype none

module apbResultPort #(
    parameter int PIXELS = 4
) (
    input  wire logic                                   clk,
    input  wire logic                                   combin_res,
    input  wire logic                                   psel,
    input  wire logic                                   penable,
    input  wire logic                                   pwrite,
    input  wire logic [peakHistPkg::APB_ADDR_W-1:0]     paddr,
    input  wire logic [peakHistPkg::APB_DATA_W-1:0]     pwdata,
    output logic [peakHistPkg::APB_DATA_W-1:0]          prdata,
    output logic                                        pready,
    output logic                                        pslverr,
    input  wire peakHistPkg::passState_e                state,
    input  wire logic [PIXELS*peakHistPkg::SAMPLE_W-1:0] result,
    output logic                                        restart
);
    import peakHistPkg::*;

    localparam int PIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;

    logic [APB_ADDR_W-1:0] offset;            // distance from result base
    logic [PIX_W-1:0] resultIdx;
    logic resultHit;
    logic mapped;
    logic setup;
    logic [APB_DATA_W-1:0] readWord;

    always_comb begin
        offset = paddr - ADDR_RESULT_BASE;
        resultIdx = offset[PIX_W+1:2];
        resultHit = (paddr >= ADDR_RESULT_BASE) && (offset[1:0] == 2'b00)
                    && ((offset >> 2) < APB_ADDR_W'(PIXELS));
        mapped = (paddr == ADDR_CTRL) || (paddr == ADDR_STATUS) || resultHit;
        readWord = '0;
        if (paddr == ADDR_STATUS) begin
            readWord[0] = (state == DONE);
            readWord[1] = (state == FINE);    // fine pass active
        end else if (resultHit) begin
            readWord[SAMPLE_W-1:0] = result[resultIdx*SAMPLE_W +: SAMPLE_W];
        end
        setup = psel && !penable;
        restart = psel && penable && pwrite && (paddr == ADDR_CTRL) && pwdata[0];
        pready = 1'b1;                        // no wait states
    end

    // response captured in setup and presented in access
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup && !mapped;
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            prdata <= (pwrite || !mapped) ? '0 : readWord;
        end
    end

endmodule

`default_nettype wire

/* source/peakHistTop.sv */
`default_nettype none

module peakHistTop #(
    parameter int PIXELS = 4,
    parameter int SAMPLES = 8,
    parameter int ACQS = 2
) (
    input  wire logic                                clk,
    input  wire logic                                combin_res,
    input  wire logic                                wrEn,
    input  wire logic [peakHistPkg::SAMPLE_W-1:0]    data,
    output logic                                     ready,
    input  wire logic                                psel,
    input  wire logic                                penable,
    input  wire logic                                pwrite,
    input  wire logic [peakHistPkg::APB_ADDR_W-1:0]  paddr,
    input  wire logic [peakHistPkg::APB_DATA_W-1:0]  pwdata,
    output logic [peakHistPkg::APB_DATA_W-1:0]       prdata,
    output logic                                     pready,
    output logic                                     pslverr
);
    import peakHistPkg::*;

    localparam int PIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;

    passState_e state;
    logic accept;
    logic passEnd, restart, finePass;
    logic clearBins, latchCoarse, latchFine;
    logic [PIX_W-1:0] pixel, pixelOut;
    logic [BIN_W-1:0] binIdx, binOut;
    logic inWindow, countValid;
    logic [COUNT_W-1:0] newCount;
    logic [PIXELS*BIN_W-1:0] coarsePeak;
    logic [PIXELS*SAMPLE_W-1:0] result;

    assign accept = wrEn && ready;            // offers while not ready are dropped

    passSequencer u_passSequencer (
        .clk(clk), .combin_res(combin_res), .passEnd(passEnd), .restart(restart),
        .ready(ready), .finePass(finePass), .clearBins(clearBins),
        .latchCoarse(latchCoarse), .latchFine(latchFine), .state(state)
    );

    sampleCounter #(.PIXELS(PIXELS), .SAMPLES(SAMPLES), .ACQS(ACQS)) u_sampleCounter (
        .clk(clk), .combin_res(combin_res), .accept(accept), .clearBins(clearBins),
        .pixel(pixel), .passEnd(passEnd)
    );

    binMapper #(.PIXELS(PIXELS)) u_binMapper (
        .data(data), .finePass(finePass), .pixel(pixel), .coarsePeak(coarsePeak),
        .binIdx(binIdx), .inWindow(inWindow)
    );

    histogramBins #(.PIXELS(PIXELS)) u_histogramBins (
        .clk(clk), .combin_res(combin_res), .accept(accept), .inWindow(inWindow),
        .pixel(pixel), .binIdx(binIdx), .clearBins(clearBins), .newCount(newCount),
        .binOut(binOut), .pixelOut(pixelOut), .countValid(countValid)
    );

    peakTracker #(.PIXELS(PIXELS)) u_peakTracker (
        .clk(clk), .combin_res(combin_res), .countValid(countValid),
        .newCount(newCount), .binOut(binOut), .pixelOut(pixelOut),
        .clearBins(clearBins), .latchCoarse(latchCoarse), .latchFine(latchFine),
        .coarsePeak(coarsePeak), .result(result)
    );

    apbResultPort #(.PIXELS(PIXELS)) u_apbResultPort (
        .clk(clk), .combin_res(combin_res), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .state(state), .result(result),
        .restart(restart)
    );

endmodule

`default_nettype wire

/* testbench/tbClockGen.sv */
`default_nettype none

module tbClockGen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;      // half period per phase
        end
    end

endmodule

`default_nettype wire

/* testbench/tbPeakHist.sv */
`default_nettype none

module tbPeakHist;
    timeunit 1ns;
    timeprecision 100ps;
    import peakHistPkg::*;

    localparam int PIXELS = 4;
    localparam int SAMPLES = 8;
    localparam int ACQS = 2;
    localparam int PASS_LEN = PIXELS * SAMPLES * ACQS;
    localparam int MAX_TS = (1 << SAMPLE_W) - 1;
    localparam int STREAM_LIMIT = 4 * PASS_LEN;
    localparam int APB_LIMIT = 8;
    localparam int DONE_LIMIT = 20;
    localparam logic [SAMPLE_W-1:0] JUNK = 'h001;     // lands in pixel 0 if ever taken

    logic clk;
    logic combin_res;
    logic wrEn;
    logic [SAMPLE_W-1:0] data;
    logic ready;
    logic psel;
    logic penable;
    logic pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic pready;
    logic pslverr;

    integer seed;
    int errors;
    int propErrors;
    bit timedOut;
    int peaks [PIXELS];                       // centre of each pixel's timestamps
    int expResult [PIXELS];
    int coarseQ [$];                          // accepted samples, in order
    int fineQ [$];

    tbClockGen #(.PERIOD_NS(100)) u_tbClockGen (.clk(clk));

    peakHistTop #(.PIXELS(PIXELS), .SAMPLES(SAMPLES), .ACQS(ACQS)) u_peakHistTop (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data), .ready(ready),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    assert property (@(posedge clk) disable iff (!combin_res) pready)
        else begin
            propErrors++;
            $display("FAILED pready: got %h exp %h", 1'b0, 1'b1);
        end

    assert property (@(posedge clk) disable iff (!combin_res) pslverr |-> (psel && penable))
        else begin
            propErrors++;
            $display("pslverr was raised outside an APB access phase");
        end

    task automatic printCounts();
        $display("immediate check errors: %0d, property check errors: %0d",
                 errors, propErrors);
    endtask

    task automatic reportTimeout(input string why);
        $display("%s", why);
        timedOut = 1'b1;
    endtask

    // a wait that ran out ends the run
    initial begin : timeoutWatch
        wait (timedOut);
        printCounts();
        $display("Errors found");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
            else begin
                errors++;
                $display("FAILED %s: got %h exp %h", name, got, exp);
            end
    endtask

    task automatic apbTransfer(input bit write, input logic [APB_ADDR_W-1:0] addr,
                               input logic [APB_DATA_W-1:0] wdata,
                               output logic [APB_DATA_W-1:0] rd, output logic err);
        int tries;
        @(posedge clk);
        psel <= 1'b1;                         // setup phase
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        tries = 0;
        @(negedge clk);
        while (!pready && tries < APB_LIMIT) begin
            @(negedge clk);
            tries++;
        end
        if (!pready) reportTimeout("timed out waiting for pready");
        rd = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic checkUnmapped(input logic [APB_ADDR_W-1:0] addr);
        logic [APB_DATA_W-1:0] rd;
        logic err;
        apbTransfer(1'b0, addr, '0, rd, err);
        checkValue($sformatf("pslverr at %h", addr), err, 1);
        checkValue($sformatf("prdata at %h", addr), rd, 0);
    endtask

    // one pass worth of samples scattered around each pixel's peak
    task automatic streamPass(input bit fine, input int pauseAt);
        logic [APB_DATA_W-1:0] rd;
        logic err;
        int accepted;
        int tries;
        int pix;
        int r;
        int v;
        accepted = 0;
        tries = 0;
        while (accepted < PASS_LEN && tries < STREAM_LIMIT) begin
            if (accepted == pauseAt) begin
                @(posedge clk);
                wrEn <= 1'b0;
                apbTransfer(1'b1, ADDR_CTRL, 1, rd, err);   // mid-pass, so ignored
                apbTransfer(1'b0, ADDR_STATUS, '0, rd, err);
                checkValue("status", rd, 2);
            end
            pix = (accepted / SAMPLES) % PIXELS;
            r = $random(seed);
            if ((r & 7) == 0) begin
                v = $random(seed) & MAX_TS;   // stray sample anywhere in range
            end else begin
                v = peaks[pix] + (r >>> 3) % 7;
            end
            if (v < 0) v = 0;
            if (v > MAX_TS) v = MAX_TS;
            @(posedge clk);
            wrEn <= 1'b1;
            data <= SAMPLE_W'(v);
            @(negedge clk);
            checkValue("ready", ready, 1);
            if (ready) begin
                if (fine) fineQ.push_back(v);
                else coarseQ.push_back(v);
                accepted++;
            end
            tries++;
        end
        if (accepted < PASS_LEN) reportTimeout("timed out streaming a pass of samples");
    endtask

    // offers while the pass is switching must be dropped
    task automatic offerJunk(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            wrEn <= 1'b1;
            data <= JUNK;
            @(negedge clk);
            checkValue("ready", ready, 0);
        end
    endtask

    function automatic int clampStart(input int bin);
        int s;
        s = (bin << (SAMPLE_W - BIN_W)) - (1 << (BIN_W - 1));
        if (s < 0) s = 0;
        if (s > (1 << SAMPLE_W) - (1 << BIN_W)) s = (1 << SAMPLE_W) - (1 << BIN_W);
        return s;
    endfunction

    task automatic predictResults();
        int cnt [PIXELS][NUM_BINS];
        int maxCnt [PIXELS];
        int maxBin [PIXELS];
        int start [PIXELS];
        int p;
        int b;
        for (p = 0; p < PIXELS; p++) begin
            maxCnt[p] = 0;
            maxBin[p] = 0;
            for (b = 0; b < NUM_BINS; b++) cnt[p][b] = 0;
        end
        foreach (coarseQ[i]) begin
            p = (i / SAMPLES) % PIXELS;
            b = coarseQ[i] >> (SAMPLE_W - BIN_W);
            cnt[p][b]++;
            if (cnt[p][b] > maxCnt[p]) begin   // strictly greater keeps first bin
                maxCnt[p] = cnt[p][b];
                maxBin[p] = b;
            end
        end
        for (p = 0; p < PIXELS; p++) begin
            start[p] = clampStart(maxBin[p]);
            maxCnt[p] = 0;
            maxBin[p] = 0;
            for (b = 0; b < NUM_BINS; b++) cnt[p][b] = 0;
        end
        foreach (fineQ[i]) begin
            p = (i / SAMPLES) % PIXELS;
            b = fineQ[i] - start[p];
            if (b >= 0 && b < NUM_BINS) begin  // outside the window is dropped
                cnt[p][b]++;
                if (cnt[p][b] > maxCnt[p]) begin
                    maxCnt[p] = cnt[p][b];
                    maxBin[p] = b;
                end
            end
        end
        for (p = 0; p < PIXELS; p++) expResult[p] = start[p] + maxBin[p];
    endtask

    task automatic runAcquisition();
        logic [APB_DATA_W-1:0] rd;
        logic err;
        int tries;
        coarseQ.delete();
        fineQ.delete();
        streamPass(1'b0, -1);
        offerJunk(2);                         // DRAIN_C
        streamPass(1'b1, PASS_LEN / 2);
        offerJunk(3);                         // DRAIN_F then DONE
        @(posedge clk);
        wrEn <= 1'b0;
        rd = '0;
        tries = 0;
        while (!rd[0] && tries < DONE_LIMIT) begin
            apbTransfer(1'b0, ADDR_STATUS, '0, rd, err);
            tries++;
        end
        if (!rd[0]) reportTimeout("timed out waiting for the done flag");
        checkValue("status", rd, 1);
        predictResults();
        for (int p = 0; p < PIXELS; p++) begin
            apbTransfer(1'b0, ADDR_RESULT_BASE + APB_ADDR_W'(4 * p), '0, rd, err);
            checkValue($sformatf("result[%0d]", p), rd, expResult[p]);
            checkValue("pslverr", err, 0);
        end
    endtask

    initial begin : mainFlow
        logic [APB_DATA_W-1:0] rd;
        logic err;
        seed = 52;
        errors = 0;
        propErrors = 0;
        timedOut = 1'b0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        data = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (16) @(posedge clk);
        combin_res <= 1'b1;
        @(negedge clk);
        checkValue("ready", ready, 1);
        apbTransfer(1'b0, ADDR_STATUS, '0, rd, err);
        checkValue("status", rd, 0);

        peaks[0] = 3;                         // window clipped at zero
        peaks[1] = 1282;
        peaks[2] = 2562;
        peaks[3] = 4090;                      // far from its bin start, window stays empty
        runAcquisition();

        checkUnmapped(8'h08);
        checkUnmapped(8'h12);
        checkUnmapped(ADDR_RESULT_BASE + APB_ADDR_W'(4 * PIXELS));

        apbTransfer(1'b1, ADDR_CTRL, 1, rd, err);
        apbTransfer(1'b0, ADDR_STATUS, '0, rd, err);
        checkValue("status", rd, 0);
        peaks[0] = 10;
        peaks[1] = 3842;
        peaks[2] = 516;
        peaks[3] = 2050;
        runAcquisition();

        printCounts();
        if (errors == 0 && propErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
source/peakHistPkg.sv
source/passSequencer.sv
source/sampleCounter.sv
source/binMapper.sv
source/histogramBins.sv
source/peakTracker.sv
source/apbResultPort.sv
source/peakHistTop.sv
testbench/tbClockGen.sv
testbench/tbPeakHist.sv

/* Bender.yml */
package:
  name: peakHist

sources:
  - source/peakHistPkg.sv
  - source/passSequencer.sv
  - source/sampleCounter.sv
  - source/binMapper.sv
  - source/histogramBins.sv
  - source/peakTracker.sv
  - source/apbResultPort.sv
  - source/peakHistTop.sv
  - target: test
    files:
      - testbench/tbClockGen.sv
      - testbench/tbPeakHist.sv
